//--- files.f
logic/cntPkg.sv
logic/refreshTimer.sv
logic/startupSeq.sv
logic/cfgRegs.sv
logic/cntTop.sv
sim/cntTb.sv

//--- Bender.yml
package:
  name: cnt

sources:
  - files:
      - logic/cntPkg.sv
      - logic/refreshTimer.sv
      - logic/startupSeq.sv
      - logic/cfgRegs.sv
      - logic/cntTop.sv
  - target: test
    files:
      - sim/cntTb.sv

//--- sim/cntTb.sv
`timescale 1ns/1ps

module cntTb;

	typedef enum logic [1:0] {
		opWrite, // APB write to the address in arg
		opRead, // APB read compared under mask
		opRun, // Run arg E falls and check pins and STATUS
		opNmi // Drive nIPL2 to data[0]
	} opT;

	typedef struct packed {
		opT op;
		logic [31:0] arg; // Address or E fall count
		logic [31:0] data;
		logic [31:0] expVal;
		logic [31:0] mask;
	} rowT;

	logic C8M;
	logic rstN;
	logic E;
	logic nIPL2;
	cntPkg::apbReqT apbReq;
	cntPkg::apbRspT apbRsp;
	logic RefReq, RefUrgent, nRESout, AoutOE, nBR_IOB;
	logic C20MEN, C25MEN, FastROMEN;

	rowT rows[$]; // Stimulus table
	int errCount = 0;
	int checkCount = 0;
	int limitCycles = 0; // Watchdog budget from the table

	// Reference model state
	int fallCnt; // E falls since the last restart
	logic [13:0] longLastM;
	logic declinedM; // Bus declined at startup
	logic nmiLowM;
	logic [2:0] enM; // Enables as in CTRL bits 2 to 0

	cntTop uut (
		.C8M(C8M),
		.rstN(rstN),
		.E(E),
		.nIPL2(nIPL2),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.RefReq(RefReq),
		.RefUrgent(RefUrgent),
		.nRESout(nRESout),
		.AoutOE(AoutOE),
		.nBR_IOB(nBR_IOB),
		.C20MEN(C20MEN),
		.C25MEN(C25MEN),
		.FastROMEN(FastROMEN)
	);

	initial begin
		C8M = 1'b0;
		forever #2 C8M = ~C8M; // 4 ns period
	end

	function automatic void addRow(opT op, logic [31:0] arg, logic [31:0] data,
		logic [31:0] expVal, logic [31:0] mask);
		rowT r;
		r.op = op;
		r.arg = arg;
		r.data = data;
		r.expVal = expVal;
		r.mask = mask;
		rows.push_back(r);
	endfunction

	// Long ticks come every (longLast + 1) rounds of 11 falls
	function automatic logic [1:0] stateModel();
		int ticks;
		ticks = fallCnt / (11 * (int'(longLastM) + 1));
		return (ticks >= 3) ? 2'd3 : ticks[1:0];
	endfunction

	function automatic logic reqModel();
		return (fallCnt % 11) >= 3; // Request window 3 to 10
	endfunction

	function automatic logic urgentModel();
		return (fallCnt % 11) >= 8; // Urgent window 8 to 10
	endfunction

	function automatic logic errRule(logic [3:0] addr, logic wr);
		if (addr != 4'h0 && addr != 4'h4 && addr != 4'h8)
			return 1'b1; // Hole in the map
		return wr && (addr == 4'h8); // STATUS is read only
	endfunction

	task automatic checkVal(input string name, input logic [31:0] expV,
		input logic [31:0] actV);
		checkCount++;
		if (actV !== expV) begin
			errCount++;
			$display("ERROR %s: expected 0x%h, got 0x%h at %0t", name, expV, actV, $time);
		end
	endtask

	// One APB transfer sampled mid-cycle in the access phase
	task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = wr;
		apbReq.paddr = addr;
		apbReq.pwdata = data;
		@(posedge C8M);
		#1;
		apbReq.penable = 1'b1;
		@(negedge C8M);
		checkVal("pready", 32'h1, apbRsp.pready); // No wait states
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		@(posedge C8M); // Transfer completes here
		#1;
		apbReq = '0;
	endtask

	task automatic modelWrite(input logic [3:0] addr, input logic [31:0] data);
		if (addr == 4'h0) begin
			enM = data[2:0];
			if (data[8]) begin
				fallCnt = 0; // Restart clears counts and sequencer
				declinedM = 1'b0;
			end
		end else if (addr == 4'h4) begin
			longLastM = data[13:0];
		end
	endtask

	task automatic checkPins();
		logic [1:0] st;
		repeat (2) @(negedge C8M); // Let the registered windows follow the count
		st = stateModel();
		checkVal("RefReq", reqModel(), RefReq);
		checkVal("RefUrgent", urgentModel(), RefUrgent);
		checkVal("nRESout", st == 2'd3, nRESout);
		checkVal("AoutOE", (st == 2'd3) && !declinedM, AoutOE);
		checkVal("nBR_IOB", declinedM, nBR_IOB);
		checkVal("C20MEN", enM[0], C20MEN);
		checkVal("C25MEN", enM[1], C25MEN);
		checkVal("FastROMEN", enM[2], FastROMEN);
		@(posedge C8M);
		#1;
	endtask

	// E with 5 cycles high and 5 low per fall
	task automatic runFalls(input int k);
		for (int i = 0; i < k; i++) begin
			E = 1'b1;
			repeat (5) begin
				@(posedge C8M);
				#1;
			end
			E = 1'b0;
			fallCnt++;
			if (stateModel() == 2'd1 && nmiLowM)
				declinedM = 1'b1; // NMI seen while sampling
			repeat (5) begin
				@(posedge C8M);
				#1;
			end
		end
	endtask

	initial begin
		int seedVal;
		int sumCycles;
		logic [31:0] rd;
		logic err;
		logic [2:0] pat;
		rstN = 1'b0;
		E = 1'b0;
		nIPL2 = 1'b1;
		apbReq = '0;
		fallCnt = 0;
		longLastM = 14'd8192;
		declinedM = 1'b0;
		nmiLowM = 1'b0;
		enM = 3'b111;
		seedVal = $urandom(32'hfc76); // Seed once for the whole run

		// Reset defaults
		addRow(opRead, 32'h0, 32'h0, 32'h7, 32'hffff_ffff);
		addRow(opRead, 32'h4, 32'h0, 32'h2000, 32'hffff_ffff);
		// Refresh windows at random fall counts
		repeat (4) begin
			addRow(opWrite, 32'h0, 32'h107, 32'h0, 32'h0);
			addRow(opRun, $urandom_range(40, 1), 32'h0, 32'h0, 32'h0);
		end
		// Startup order with a short long interval
		addRow(opWrite, 32'h4, 32'h2, 32'h0, 32'h0);
		addRow(opWrite, 32'h0, 32'h107, 32'h0, 32'h0);
		addRow(opRead, 32'h8, 32'h0, 32'h0, 32'hffff_ffff); // stHold right after restart
		repeat (3) addRow(opRun, 32'd33, 32'h0, 32'h0, 32'h0);
		addRow(opRead, 32'h8, 32'h0, 32'h18, 32'h19); // stRun with the bus taken
		// NMI held during stSample
		addRow(opNmi, 32'h0, 32'h0, 32'h0, 32'h0);
		addRow(opWrite, 32'h0, 32'h107, 32'h0, 32'h0);
		addRow(opRun, 32'd33, 32'h0, 32'h0, 32'h0);
		addRow(opRun, 32'd33, 32'h0, 32'h0, 32'h0);
		addRow(opNmi, 32'h0, 32'h1, 32'h0, 32'h0);
		addRow(opRun, 32'd33, 32'h0, 32'h0, 32'h0);
		addRow(opRead, 32'h8, 32'h0, 32'h19, 32'h19); // stRun with the bus declined
		// Register access
		repeat (4) begin
			pat = $urandom;
			addRow(opWrite, 32'h0, {29'h0, pat}, 32'h0, 32'h0);
			addRow(opRead, 32'h0, 32'h0, {29'h0, pat}, 32'h1ff);
		end
		pat = $urandom;
		addRow(opWrite, 32'h0, {23'h0, 1'b1, 5'h0, pat}, 32'h0, 32'h0);
		addRow(opRead, 32'h0, 32'h0, {29'h0, pat}, 32'h1ff); // Restart bit reads 0
		addRow(opWrite, 32'hc, 32'h5a, 32'h0, 32'h0);
		addRow(opRead, 32'hc, 32'h0, 32'h0, 32'h0);
		addRow(opWrite, 32'h8, 32'h1f, 32'h0, 32'h0);

		sumCycles = 10; // Reset and first check
		foreach (rows[i])
			sumCycles += (rows[i].op == opRun) ? 10 * rows[i].arg + 8 : 8;
		limitCycles = 2 * sumCycles;

		repeat (3) @(posedge C8M);
		#1;
		rstN = 1'b1;
		checkPins();

		foreach (rows[i]) begin
			case (rows[i].op)
				opWrite: begin
					apbXfer(1'b1, rows[i].arg[3:0], rows[i].data, rd, err);
					checkVal("pslverr", errRule(rows[i].arg[3:0], 1'b1), err);
					modelWrite(rows[i].arg[3:0], rows[i].data);
					checkPins();
				end
				opRead: begin
					apbXfer(1'b0, rows[i].arg[3:0], 32'h0, rd, err);
					checkVal("pslverr", errRule(rows[i].arg[3:0], 1'b0), err);
					checkVal("prdata", rows[i].expVal & rows[i].mask, rd & rows[i].mask);
				end
				opRun: begin
					runFalls(rows[i].arg);
					checkPins();
					apbXfer(1'b0, 4'h8, 32'h0, rd, err);
					checkVal("STATUS", {27'h0, stateModel(), reqModel(), urgentModel(),
						declinedM}, rd);
				end
				default: begin
					nIPL2 = rows[i].data[0];
					nmiLowM = !rows[i].data[0];
					if (stateModel() == 2'd1 && nmiLowM)
						declinedM = 1'b1;
					checkPins();
				end
			endcase
		end

		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog armed once the table length is known
	initial begin
		wait (limitCycles != 0);
		repeat (limitCycles) @(posedge C8M);
		$display("Timeout: run did not finish within %0d cycles", limitCycles);
		$display("Test failed");
		$finish;
	end

endmodule

//--- logic/cntTop.sv
`timescale 1ns/1ps

module cntTop (
	input logic C8M, // Main clock, rising edge
	input logic rstN, // Sync reset, active low
	input logic E, // Slow E clock from the PDS
	input logic nIPL2, // NMI button
	input cntPkg::apbReqT apbReq, // Config bus request
	output cntPkg::apbRspT apbRsp, // Config bus response
	output logic RefReq, // To the DRAM controller
	output logic RefUrgent,
	output logic nRESout, // Card reset
	output logic AoutOE, // PDS address and control enable
	output logic nBR_IOB, // PDS bus request
	output logic C20MEN, // Oscillator enables
	output logic C25MEN,
	output logic FastROMEN // Fast ROM enable
);

	cntPkg::cfgT cfg;
	cntPkg::statusT status;
	cntPkg::seqStateT seqState;
	logic restart; // From CTRL write
	logic longTick; // Timer to sequencer

	assign status = '{state: seqState, refReq: RefReq, refUrgent: RefUrgent,
		busDeclined: nBR_IOB};

	assign C20MEN = cfg.c20mEn;
	assign C25MEN = cfg.c25mEn;
	assign FastROMEN = cfg.fastRomEn;

	refreshTimer uRefreshTimer (
		.C8M(C8M),
		.rstN(rstN),
		.E(E),
		.restart(restart),
		.longLast(cfg.longLast),
		.refReq(RefReq),
		.refUrgent(RefUrgent),
		.longTick(longTick)
	);

	startupSeq uStartupSeq (
		.C8M(C8M),
		.rstN(rstN),
		.restart(restart),
		.longTick(longTick),
		.nIPL2(nIPL2),
		.state(seqState),
		.nRESout(nRESout),
		.AoutOE(AoutOE),
		.nBR_IOB(nBR_IOB)
	);

	cfgRegs uCfgRegs (
		.C8M(C8M),
		.rstN(rstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.status(status),
		.cfg(cfg),
		.restart(restart)
	);

endmodule

//--- logic/cfgRegs.sv
`timescale 1ns/1ps

module cfgRegs (
	input logic C8M, // Main clock, rising edge
	input logic rstN, // Sync reset, active low
	input cntPkg::apbReqT apbReq, // APB request
	output cntPkg::apbRspT apbRsp, // APB response
	input cntPkg::statusT status, // Sequencer and refresh status
	output cntPkg::cfgT cfg, // Enables and long interval
	output logic restart // One-cycle restart command
);

	// Register map
	// 0x0 CTRL   [0] C20M en, [1] C25M en, [2] fast ROM en, [8] restart (reads 0)
	// 0x4 LONG   [13:0] last long count
	// 0x8 STATUS [4:3] state, [2] refReq, [1] refUrgent, [0] busDeclined

	logic access; // Access phase, transfer completes now
	logic wrAcc;
	logic rdEn;
	logic unmapped; // Address hits no register
	logic [31:0] rdData;

	assign access = apbReq.psel & apbReq.penable;
	assign wrAcc = access & apbReq.pwrite;
	assign rdEn = apbReq.psel & ~apbReq.pwrite;

	// Restart acts at the write edge, no extra cycle
	assign restart = wrAcc && (apbReq.paddr == cntPkg::addrCtrl) &&
		apbReq.pwdata[cntPkg::ctrlRestartBit];

	always_ff @(posedge C8M) begin
		if (!rstN) begin
			cfg.c20mEn <= 1'b1; // Both oscillators on, only one is mounted
			cfg.c25mEn <= 1'b1;
			cfg.fastRomEn <= 1'b1;
			cfg.longLast <= cntPkg::longLastReset;
		end else if (wrAcc) begin
			case (apbReq.paddr)
				cntPkg::addrCtrl: begin
					cfg.c20mEn <= apbReq.pwdata[cntPkg::ctrlC20mBit];
					cfg.c25mEn <= apbReq.pwdata[cntPkg::ctrlC25mBit];
					cfg.fastRomEn <= apbReq.pwdata[cntPkg::ctrlFastRomBit];
				end
				cntPkg::addrLong: begin
					cfg.longLast <= apbReq.pwdata[cntPkg::longW-1:0];
				end
				default: begin
					cfg <= cfg; // STATUS and holes are not writable
				end
			endcase
		end
	end

	// Read mux and address decode
	always_comb begin
		rdData = '0;
		unmapped = 1'b0;
		case (apbReq.paddr)
			cntPkg::addrCtrl: begin
				rdData[cntPkg::ctrlC20mBit] = cfg.c20mEn;
				rdData[cntPkg::ctrlC25mBit] = cfg.c25mEn;
				rdData[cntPkg::ctrlFastRomBit] = cfg.fastRomEn;
			end
			cntPkg::addrLong: begin
				rdData[cntPkg::longW-1:0] = cfg.longLast;
			end
			cntPkg::addrStatus: begin
				rdData[$bits(cntPkg::statusT)-1:0] = status;
			end
			default: begin
				unmapped = 1'b1;
			end
		endcase
	end

	assign apbRsp.prdata = rdEn ? rdData : '0; // Quiet bus when not reading
	assign apbRsp.pready = 1'b1; // Never stalls

	// Error on holes, or on a write to the read-only STATUS
	assign apbRsp.pslverr = access &&
		(unmapped || (apbReq.pwrite && (apbReq.paddr == cntPkg::addrStatus)));

	// Every access phase completes in one cycle
	aNoWait: assert property (@(posedge C8M) disable iff (!rstN)
		access |-> apbRsp.pready)
		else $error("APB access stalled");

endmodule

//--- logic/startupSeq.sv
`timescale 1ns/1ps

module startupSeq (
	input logic C8M, // Main clock, rising edge
	input logic rstN, // Sync reset, active low
	input logic restart, // Back to stHold
	input logic longTick, // Step to the next state
	input logic nIPL2, // NMI button, async, active low
	output cntPkg::seqStateT state, // Current state
	output logic nRESout, // Card reset, active low
	output logic AoutOE, // PDS address and control enable
	output logic nBR_IOB // Bus request, 1 means declined
);

	cntPkg::seqStateT stateNext;
	logic [1:0] nIplSync; // Two-flop synchronizer, [1] is safe to use

	always_ff @(posedge C8M) begin
		if (!rstN) begin
			nIplSync <= 2'b11; // Button released
		end else begin
			nIplSync <= {nIplSync[0], nIPL2};
		end
	end

	// One step per long tick, stRun is final
	always_comb begin
		stateNext = state;
		if (longTick) begin
			case (state)
				cntPkg::stHold: stateNext = cntPkg::stSample;
				cntPkg::stSample: stateNext = cntPkg::stSettle;
				cntPkg::stSettle: stateNext = cntPkg::stRun;
				cntPkg::stRun: stateNext = cntPkg::stRun;
				default: stateNext = cntPkg::stHold;
			endcase
		end
	end

	always_ff @(posedge C8M) begin
		if (!rstN || restart) begin
			state <= cntPkg::stHold;
		end else begin
			state <= stateNext;
		end
	end

	// Outputs come from the registered state, so they trail a tick by one clock
	always_ff @(posedge C8M) begin
		if (!rstN || restart) begin
			nRESout <= 1'b0;
			AoutOE <= 1'b0;
			nBR_IOB <= 1'b0;
		end else begin
			case (state)
				cntPkg::stHold: begin
					nRESout <= 1'b0; // Keep card in reset
					AoutOE <= 1'b0; // PDS address lines tristated
					nBR_IOB <= 1'b0; // Default is to take the bus
				end
				cntPkg::stSample: begin
					nRESout <= 1'b0;
					AoutOE <= 1'b0;
					nBR_IOB <= nBR_IOB | ~nIplSync[1]; // NMI held, decline the bus
				end
				cntPkg::stSettle: begin
					nRESout <= 1'b0;
					AoutOE <= 1'b0; // Decision frozen from here on
				end
				cntPkg::stRun: begin
					nRESout <= 1'b1; // Release reset
					AoutOE <= ~nBR_IOB; // Drive PDS only if the bus was taken
				end
				default: begin
					nRESout <= 1'b0;
					AoutOE <= 1'b0;
				end
			endcase
		end
	end

	// Reset release only ever follows a completed sequence
	aResOnlyInRun: assert property (@(posedge C8M) disable iff (!rstN)
		nRESout |-> (state == cntPkg::stRun))
		else $error("nRESout high outside stRun");

endmodule

//--- logic/refreshTimer.sv
`timescale 1ns/1ps

module refreshTimer (
	input logic C8M, // Main clock, rising edge
	input logic rstN, // Sync reset, active low
	input logic E, // Slow 68000 E clock
	input logic restart, // Clears both counts
	input logic [cntPkg::longW-1:0] longLast, // Last long count
	output logic refReq, // Refresh request window
	output logic refUrgent, // Urgent refresh window
	output logic longTick // One pulse per long interval
);

	// Refresh round
	// | count | refReq | refUrgent |
	// |  0-2  |   0    |     0     |
	// |  3-7  |   1    |     0     |
	// |  8-10 |   1    |     1     |
	// Each count lasts one E period, so a round is 11 E periods

	logic eDly; // Registered copy of E
	logic eFall; // E just went low
	logic refWrap; // Last count of the round, on an E fall
	logic [cntPkg::refW-1:0] refCnt; // 0 to 10
	logic [cntPkg::longW-1:0] longCnt; // 0 to longLast

	assign eFall = eDly & ~E; // Seen one cycle after E first samples low
	assign refWrap = eFall && (refCnt == cntPkg::refLast);

	// Long tick lands in the same cycle as the long count wraps
	assign longTick = refWrap && (longCnt >= longLast);

	always_ff @(posedge C8M) begin
		if (!rstN) begin
			eDly <= 1'b0; // No spurious fall out of reset
		end else begin
			eDly <= E;
		end
	end

	always_ff @(posedge C8M) begin
		if (!rstN || restart) begin
			refCnt <= '0;
		end else if (refWrap) begin
			refCnt <= '0; // Start next round
		end else if (eFall) begin
			refCnt <= refCnt + 1'b1;
		end
	end

	always_ff @(posedge C8M) begin
		if (!rstN || restart) begin
			longCnt <= '0;
		end else if (longTick) begin
			longCnt <= '0; // Also catches a longLast lowered below the count
		end else if (refWrap) begin
			longCnt <= longCnt + 1'b1;
		end
	end

	// Windows follow the count one clock later
	always_ff @(posedge C8M) begin
		if (!rstN) begin
			refReq <= 1'b0;
			refUrgent <= 1'b0;
		end else begin
			refReq <= (refCnt >= cntPkg::refReqFirst);
			refUrgent <= (refCnt >= cntPkg::refUrgentFirst);
		end
	end

	// Urgent window sits inside the request window
	aUrgentInReq: assert property (@(posedge C8M) disable iff (!rstN)
		refUrgent |-> refReq)
		else $error("refUrgent high outside the refReq window");

	// E fall lasts one cycle, so the tick does too
	aTickSingle: assert property (@(posedge C8M) disable iff (!rstN)
		longTick |=> !longTick)
		else $error("longTick held for two cycles");

endmodule

//--- logic/cntPkg.sv
package cntPkg;

	// Refresh timer limits, counted in E falls
	localparam int refW = 4; // Refresh count width
	localparam logic [refW-1:0] refLast = 4'd10; // Count wraps to 0 after this value
	localparam logic [refW-1:0] refReqFirst = 4'd3; // RefReq window opens here
	localparam logic [refW-1:0] refUrgentFirst = 4'd8; // RefUrgent window opens here

	// Long interval, counted in refresh rounds
	localparam int longW = 14; // Long count width
	localparam logic [longW-1:0] longLastReset = 14'd8192; // About 115 ms at 783 kHz E

	// APB register map
	localparam int addrW = 4; // Byte address width of the register block
	localparam logic [addrW-1:0] addrCtrl = 4'h0; // Enables and restart command
	localparam logic [addrW-1:0] addrLong = 4'h4; // Long interval length
	localparam logic [addrW-1:0] addrStatus = 4'h8; // Sequencer and refresh status, read only

	// CTRL bit positions
	localparam int ctrlC20mBit = 0; // 20 MHz oscillator enable
	localparam int ctrlC25mBit = 1; // 25 MHz oscillator enable
	localparam int ctrlFastRomBit = 2; // Fast ROM enable
	localparam int ctrlRestartBit = 8; // Self-clearing restart command

	// APB request from the host side
	typedef struct packed {
		logic psel; // Slave select
		logic penable; // Access phase
		logic pwrite; // 1 for write
		logic [addrW-1:0] paddr; // Register byte address
		logic [31:0] pwdata; // Write data
	} apbReqT;

	// APB response from the register block
	typedef struct packed {
		logic [31:0] prdata; // Read data
		logic pready; // Transfer done, no wait states
		logic pslverr; // Unmapped address or read-only write
	} apbRspT;

	// Configuration held by the register block
	typedef struct packed {
		logic c20mEn; // Drives C20MEN
		logic c25mEn; // Drives C25MEN
		logic fastRomEn; // Drives FastROMEN
		logic [longW-1:0] longLast; // Last long count before the tick
	} cfgT;

	// Startup sequencer states, one step per long tick
	typedef enum logic [1:0] {
		stHold, // Card held in reset
		stSample, // NMI button sampled
		stSettle, // Bus decision settles
		stRun // Reset released
	} seqStateT;

	// Status word, readable at addrStatus
	typedef struct packed {
		seqStateT state; // Current sequencer state
		logic refReq; // Refresh request pin
		logic refUrgent; // Urgent refresh pin
		logic busDeclined; // NMI held at startup, card stays off the bus
	} statusT;

endpackage
